//--- common/muldiv_consts.svh
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// operand and result word width
`define MULDIV_W 64

// serial lanes in the cluster
`define MULDIV_LANES 4

// request tag, returned with the result
`define MULDIV_TAG_W 4

// lane busy cycles, start strobe to done strobe
// full width: 64 iterations plus finishing stages
`define MULDIV_MUL_CYCLES 66
`define MULDIV_DIV_CYCLES 67
// word mode: 32 iterations plus the same finishing stages
`define MULDIV_MULW_CYCLES 34
`define MULDIV_DIVW_CYCLES 35

`endif

//--- common/mulDivPkg.sv
`default_nettype none

`include "muldiv_consts.svh"

package mulDivPkg;

	// bit 1 selects divide, bit 0 selects signed
	typedef enum logic [1:0]
	{
		opMulU = 2'd0,
		opMulS = 2'd1,
		opDivU = 2'd2,
		opDivS = 2'd3
	} mulDivOp_t;

	// one bit per lane, used for free and start vectors
	typedef logic [`MULDIV_LANES-1:0] laneMask_t;

	// request as it enters the cluster
	// also the job handed from dispatcher to lane
	typedef struct packed
	{
		mulDivOp_t op;
		// word mode, low 32 bits of each operand only
		logic word;
		logic [`MULDIV_TAG_W-1:0] tag;
		// multiplicand / dividend
		logic [`MULDIV_W-1:0] a;
		// multiplier / divisor
		logic [`MULDIV_W-1:0] b;
	} mulDivReq_t;

	// finished result, tagged
	// mul: lo/hi halves of the product
	// div: quotient in lo, remainder in hi
	typedef struct packed
	{
		logic [`MULDIV_TAG_W-1:0] tag;
		logic [`MULDIV_W-1:0] lo;
		logic [`MULDIV_W-1:0] hi;
	} mulDivRes_t;

endpackage

`default_nettype wire

//--- logic/opDispatch.sv
`default_nettype none

module opDispatch
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic reqValid,
	input wire mulDivPkg::mulDivReq_t req,
	input wire mulDivPkg::laneMask_t laneFree,
	output mulDivPkg::laneMask_t laneStart,
	output mulDivPkg::mulDivReq_t laneJob,
	output logic reqReject
);

	localparam int Lanes = $bits(mulDivPkg::laneMask_t);

	// lanes really available this cycle
	mulDivPkg::laneMask_t avail;
	// one-hot choice, lowest free lane wins
	mulDivPkg::laneMask_t pick;

	// collector marks a lane busy one cycle after its start strobe,
	// so the lane being started right now still looks free there
	assign avail = laneFree & ~laneStart;

	// priority encoder, walk down so the lowest index is the last to win
	always_comb
	begin
		pick = '0;
		for (int i = Lanes - 1; i >= 0; i--)
		begin
			if (avail[i])
			begin
				pick = '0;
				pick[i] = 1'b1;
			end
		end
	end

	// start mask and reject strobe, one cycle after the request
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			laneStart <= '0;
			reqReject <= 1'b0;
		end
		else
		begin
			// strobes, so both drop back low without a request
			laneStart <= reqValid ? pick : '0;
			// no back-pressure, all lanes taken means the request is lost
			reqReject <= reqValid && (avail == '0);
		end
	end

	// shared job bus, only the lane with its start bit set loads it
	always_ff @(posedge clock)
	begin
		if (reqValid)
		begin
			laneJob <= req;
		end
	end

endmodule

`default_nettype wire

//--- slowMulDiv/slowMulDivLane.sv
`default_nettype none

`include "muldiv_consts.svh"

module slowMulDivLane
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic start,
	input wire mulDivPkg::mulDivReq_t job,
	output logic done,
	output mulDivPkg::mulDivRes_t res
);

	localparam int W = `MULDIV_W;
	localparam int H = W / 2;

	// operation held for the whole run
	mulDivPkg::mulDivOp_t op;
	logic word;
	logic [`MULDIV_TAG_W-1:0] tag;

	// acc/q pair: product hi/lo for mul, remainder/quotient for div
	logic [W-1:0] acc;
	logic [W-1:0] q;
	// multiplicand, or complemented divisor for div
	logic [W-1:0] d;
	// carry-in completing the two's complement of the divisor
	logic dC;
	// sign fixups still to apply
	logic negQ;
	logic negR;
	// remaining cycles until done
	logic [6:0] cnt;

	// start decode
	logic sa;
	logic sb;
	logic [W-1:0] aMag;
	logic [W-1:0] bMag;
	logic [6:0] jobCycles;

	// shared adder
	logic [W:0] addX;
	logic [W:0] addY;
	logic [W+1:0] sum;
	logic take;
	logic [W:0] mulNext;

	// finishing
	logic [2*W-1:0] prodMag;
	logic [2*W-1:0] prodSgn;
	logic [W-1:0] loRaw;
	logic [W-1:0] hiRaw;

	// magnitude of an operand, confined to 32 bits in word mode
	function automatic logic [W-1:0] magOf(input logic [W-1:0] x, input logic neg,
		input logic w);
		logic [W-1:0] v;
		logic [W-1:0] n;
		v = w ? {{H{1'b0}}, x[H-1:0]} : x;
		n = -v;
		if (w)
			n[W-1:H] = '0;
		return neg ? n : v;
	endfunction

	// word mode result extension from bit 31
	function automatic logic [W-1:0] extOf(input logic [W-1:0] x, input logic w,
		input logic sgn);
		return w ? {{H{sgn & x[H-1]}}, x[H-1:0]} : x;
	endfunction

	// sign bits only for signed ops, op[0]
	assign sa = job.op[0] & (job.word ? job.a[H-1] : job.a[W-1]);
	assign sb = job.op[0] & (job.word ? job.b[H-1] : job.b[W-1]);
	assign aMag = magOf(job.a, sa, job.word);
	assign bMag = magOf(job.b, sb, job.word);

	always_comb
	begin
		if (job.op[1])
			jobCycles = job.word ? 7'(`MULDIV_DIVW_CYCLES) : 7'(`MULDIV_DIV_CYCLES);
		else
			jobCycles = job.word ? 7'(`MULDIV_MULW_CYCLES) : 7'(`MULDIV_MUL_CYCLES);
	end

	// mul: acc + d
	// div: {acc, next dividend bit} - divisor, top of ~divisor is dC
	assign addX = op[1] ? {acc, q[W-1]} : {1'b0, acc};
	assign addY = {dC, d};
	assign sum = {1'b0, addX} + {1'b0, addY} + (W+2)'(dC);
	// carry out means no borrow, divisor fits
	assign take = sum[W+1];
	// mul adds only when the current multiplier bit is set
	assign mulNext = q[0] ? sum[W:0] : {1'b0, acc};

	// word mul product sits in acc[31:0] and q[63:32]
	assign prodMag = (!op[1] && word) ? {{W{1'b0}}, acc[H-1:0], q[W-1:H]} : {acc, q};
	assign prodSgn = negQ ? -prodMag : prodMag;
	// div was already negated in place one cycle earlier
	assign loRaw = op[1] ? q : prodSgn[W-1:0];
	always_comb
	begin
		if (op[1])
			hiRaw = acc;
		else if (word)
			hiRaw = {{H{1'b0}}, prodSgn[W-1:H]};
		else
			hiRaw = prodSgn[2*W-1:W];
	end

	// cycle counter and done strobe
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			// done falls in cycle start + N
			done <= (cnt == 7'd1);
			if (start)
				cnt <= jobCycles - 7'd1;
			else if (cnt != '0)
				cnt <= cnt - 7'd1;
		end
	end

	// datapath
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			op <= job.op;
			word <= job.word;
			tag <= job.tag;
			acc <= '0;
			// word divide shifts the dividend to the top, so 32 steps use it
			if (job.op[1] && job.word)
				q <= {aMag[H-1:0], {H{1'b0}}};
			else
				q <= aMag;
			d <= job.op[1] ? ~bMag : bMag;
			dC <= job.op[1];
			// divide by zero leaves a quotient of all ones in magnitude, keep it unsigned
			negQ <= (sa ^ sb) & ~(job.op[1] && bMag == '0);
			// remainder follows the dividend
			negR <= job.op[1] & sa;
		end
		else if (cnt > (op[1] ? 7'd2 : 7'd1))
		begin
			if (op[1])
			begin
				// restoring step, quotient bit shifts in at the bottom
				acc <= take ? sum[W-1:0] : {acc[W-2:0], q[W-1]};
				q <= {q[W-2:0], take};
			end
			else
			begin
				// shift-add, product bits shift in at the top of q
				acc <= mulNext[W:1];
				q <= {mulNext[0], q[W-1:1]};
			end
		end
		else if (op[1] && cnt == 7'd2)
		begin
			// extra divide stage, sign fixup in place
			q <= negQ ? -q : q;
			acc <= negR ? -acc : acc;
			negQ <= 1'b0;
			negR <= 1'b0;
		end
		if (cnt == 7'd1)
		begin
			res.tag <= tag;
			res.lo <= extOf(loRaw, word, op[0]);
			res.hi <= extOf(hiRaw, word, op[0]);
		end
	end

endmodule

`default_nettype wire

//--- logic/resultCollect.sv
`default_nettype none

`include "muldiv_consts.svh"

module resultCollect
(
	input wire logic clock,
	input wire logic arstN,
	input wire mulDivPkg::laneMask_t laneStart,
	input wire mulDivPkg::laneMask_t laneDone,
	input wire mulDivPkg::mulDivRes_t laneRes [`MULDIV_LANES],
	output mulDivPkg::laneMask_t laneFree,
	output logic resValid,
	output mulDivPkg::mulDivRes_t res
);

	localparam int Lanes = `MULDIV_LANES;
	localparam int PtrW = (Lanes > 1) ? $clog2(Lanes) : 1;

	// lane running a job
	mulDivPkg::laneMask_t busy;
	// slot holds a result not yet sent
	mulDivPkg::laneMask_t full;
	mulDivPkg::laneMask_t emitMask;
	mulDivPkg::mulDivRes_t slot [Lanes];

	// round-robin start point and the slot chosen this cycle
	logic [PtrW-1:0] ptr;
	logic [PtrW-1:0] sel;

	// first full slot at or after ptr
	always_comb
	begin
		int idx;
		resValid = 1'b0;
		sel = ptr;
		for (int k = 0; k < Lanes; k++)
		begin
			idx = (int'(ptr) + k) % Lanes;
			if (!resValid && full[idx])
			begin
				resValid = 1'b1;
				sel = PtrW'(idx);
			end
		end
	end

	// straight from the slot registers, one cycle after capture
	assign res = slot[sel];
	assign emitMask = resValid ? (mulDivPkg::laneMask_t'(1) << sel) : '0;

	// a lane takes work only with nothing running and nothing waiting
	assign laneFree = ~(busy | full);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			busy <= '0;
			full <= '0;
			ptr <= '0;
		end
		else
		begin
			busy <= (busy | laneStart) & ~laneDone;
			// capture wins over drain, though one lane never does both at once
			full <= (full & ~emitMask) | laneDone;
			// move just past the lane served
			if (resValid)
				ptr <= (int'(sel) == Lanes - 1) ? '0 : sel + 1'b1;
		end
	end

	// result slots
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < Lanes; i++)
		begin
			if (laneDone[i])
				slot[i] <= laneRes[i];
		end
	end

endmodule

`default_nettype wire

//--- logic/mulDivCluster.sv
`default_nettype none

`include "muldiv_consts.svh"

module mulDivCluster
(
	input wire logic clock,
	input wire logic arstN,
	input wire logic reqValid,
	input wire mulDivPkg::mulDivReq_t req,
	output logic reqReject,
	output logic resValid,
	output mulDivPkg::mulDivRes_t res
);

	// dispatcher to lanes
	wire mulDivPkg::laneMask_t laneStart;
	wire mulDivPkg::mulDivReq_t laneJob;
	// lanes to collector
	wire mulDivPkg::laneMask_t laneDone;
	wire mulDivPkg::mulDivRes_t laneRes [`MULDIV_LANES];
	// collector back to dispatcher
	wire mulDivPkg::laneMask_t laneFree;

	opDispatch dispatch
	(
		.clock(clock),
		.arstN(arstN),
		.reqValid(reqValid),
		.req(req),
		.laneFree(laneFree),
		.laneStart(laneStart),
		.laneJob(laneJob),
		.reqReject(reqReject)
	);

	// identical serial lanes, all watching the one job bus
	for (genvar i = 0; i < `MULDIV_LANES; i++)
	begin : genLane
		slowMulDivLane lane
		(
			.clock(clock),
			.arstN(arstN),
			.start(laneStart[i]),
			.job(laneJob),
			.done(laneDone[i]),
			.res(laneRes[i])
		);
	end

	resultCollect collect
	(
		.clock(clock),
		.arstN(arstN),
		.laneStart(laneStart),
		.laneDone(laneDone),
		.laneRes(laneRes),
		.laneFree(laneFree),
		.resValid(resValid),
		.res(res)
	);

endmodule

`default_nettype wire

//--- tests/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// xorshift32 step, returns the next state
function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// 32-bit value widened to 64, by sign for signed ops, else by zeros
function automatic logic [63:0] widen(input logic [63:0] v, input logic sgn);
	return {{32{sgn & v[31]}}, v[31:0]};
endfunction

// expected lo/hi straight from the arithmetic rules
function automatic mulDivPkg::mulDivRes_t expectRes(input mulDivPkg::mulDivReq_t r);
	logic isDiv;
	logic sgn;
	logic sx;
	logic sy;
	logic [63:0] ones;
	logic [63:0] minV;
	logic [63:0] x;
	logic [63:0] y;
	logic [63:0] mx;
	logic [63:0] my;
	logic [63:0] qv;
	logic [63:0] rv;
	logic [127:0] ea;
	logic [127:0] eb;
	logic [127:0] prod;
	mulDivPkg::mulDivRes_t e;
	isDiv = (r.op == mulDivPkg::opDivU) || (r.op == mulDivPkg::opDivS);
	sgn = (r.op == mulDivPkg::opMulS) || (r.op == mulDivPkg::opDivS);
	// operand width mask and most negative value
	ones = r.word ? 64'h0000_0000_FFFF_FFFF : 64'hFFFF_FFFF_FFFF_FFFF;
	minV = r.word ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
	x = r.a & ones;
	y = r.b & ones;
	sx = sgn && ((x & minV) != 64'd0);
	sy = sgn && ((y & minV) != 64'd0);
	e.tag = r.tag;
	if (!isDiv)
	begin
		// sign-extended to 128, the low 128 bits are the signed product
		ea = r.word ? {{96{sx}}, x[31:0]} : {{64{sx}}, x};
		eb = r.word ? {{96{sy}}, y[31:0]} : {{64{sy}}, y};
		prod = ea * eb;
		e.lo = r.word ? widen(prod[63:0], sgn) : prod[63:0];
		e.hi = r.word ? widen({32'd0, prod[63:32]}, sgn) : prod[127:64];
	end
	else
	begin
		if (y == 64'd0)
		begin
			// divide by zero
			qv = ones;
			rv = x;
		end
		else if (sgn && x == minV && y == ones)
		begin
			// signed overflow
			qv = minV;
			rv = 64'd0;
		end
		else
		begin
			mx = sx ? ((-x) & ones) : x;
			my = sy ? ((-y) & ones) : y;
			qv = mx / my;
			rv = mx % my;
			// remainder follows the dividend
			if (sx ^ sy)
				qv = (-qv) & ones;
			if (sx)
				rv = (-rv) & ones;
		end
		e.lo = r.word ? widen(qv, sgn) : qv;
		e.hi = r.word ? widen(rv, sgn) : rv;
	end
	return e;
endfunction

// result port against the model
task automatic checkRes(input mulDivPkg::mulDivRes_t got, input mulDivPkg::mulDivRes_t exp);
	if (got !== exp)
	begin
		$display("[FAIL] res tag %h lo %h hi %h, expected tag %h lo %h hi %h",
			got.tag, got.lo, got.hi, exp.tag, exp.lo, exp.hi);
		stopRun();
	end
endtask

// reject strobe, one cycle after the request
task automatic checkReject(input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("[FAIL] reqReject got %h expected %h", got, exp);
		stopRun();
	end
endtask

`endif

//--- tests/mulDivClusterTb.sv
`default_nettype none

`include "muldiv_consts.svh"

module mulDivClusterTb;

	localparam int Lanes = `MULDIV_LANES;
	localparam int FixedRows = 20;
	localparam int RandRows = 12;
	localparam int Rows = FixedRows + RandRows;
	localparam int Tags = 1 << `MULDIV_TAG_W;

	// stimulus row with the tag left to the row index
	typedef struct packed
	{
		mulDivPkg::mulDivOp_t op;
		logic word;
		logic [63:0] a;
		logic [63:0] b;
	} stimRow_t;

	logic clock;
	logic arstN;
	logic reqValid;
	mulDivPkg::mulDivReq_t req;
	logic reqReject;
	logic resValid;
	mulDivPkg::mulDivRes_t res;

	stimRow_t stim [Rows];
	// scoreboard indexed by tag
	mulDivPkg::mulDivRes_t expected [Tags];
	logic pending [Tags];
	int outstanding;
	logic [31:0] seed;

	mulDivCluster UUT
	(
		.clock(clock),
		.arstN(arstN),
		.reqValid(reqValid),
		.req(req),
		.reqReject(reqReject),
		.resValid(resValid),
		.res(res)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	task automatic stopRun();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	`include "tbChecks.svh"

	function automatic stimRow_t makeRow(input mulDivPkg::mulDivOp_t op, input logic word,
		input logic [63:0] a, input logic [63:0] b);
		stimRow_t s;
		s.op = op;
		s.word = word;
		s.a = a;
		s.b = b;
		return s;
	endfunction

	task automatic fillTable();
		// full-width multiply with top bits set and neg times neg
		stim[0] = makeRow(mulDivPkg::opMulU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF);
		stim[1] = makeRow(mulDivPkg::opMulU, 1'b0, 64'h1234_5678_9ABC_DEF0, 64'h0FED_CBA9_8765_4321);
		stim[2] = makeRow(mulDivPkg::opMulS, 1'b0, 64'hFFFF_FFFF_FFFF_FFFD, 64'd5);
		stim[3] = makeRow(mulDivPkg::opMulS, 1'b0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
		stim[4] = makeRow(mulDivPkg::opMulS, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFF7);
		// full-width divide in all sign combinations
		stim[5] = makeRow(mulDivPkg::opDivU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd3);
		stim[6] = makeRow(mulDivPkg::opDivU, 1'b0, 64'h8000_0000_0000_0000, 64'h10);
		stim[7] = makeRow(mulDivPkg::opDivS, 1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7);
		stim[8] = makeRow(mulDivPkg::opDivS, 1'b0, 64'd100, 64'hFFFF_FFFF_FFFF_FFF9);
		stim[9] = makeRow(mulDivPkg::opDivS, 1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9);
		// divide by zero and overflow
		stim[10] = makeRow(mulDivPkg::opDivU, 1'b0, 64'h1234, 64'd0);
		stim[11] = makeRow(mulDivPkg::opDivS, 1'b0, 64'hFFFF_FFFF_FFFF_FFFB, 64'd0);
		stim[12] = makeRow(mulDivPkg::opDivS, 1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
		// word mode with garbage in the upper halves
		stim[13] = makeRow(mulDivPkg::opMulU, 1'b1, 64'hDEAD_BEEF_FFFF_FFFF, 64'hCAFE_F00D_FFFF_FFFF);
		stim[14] = makeRow(mulDivPkg::opMulS, 1'b1, 64'h5555_5555_FFFF_FFFE, 64'hAAAA_AAAA_0000_0003);
		stim[15] = makeRow(mulDivPkg::opDivU, 1'b1, 64'hFFFF_0000_8000_0000, 64'h1234_5678_0000_0007);
		stim[16] = makeRow(mulDivPkg::opDivS, 1'b1, 64'h0BAD_F00D_FFFF_FF9C, 64'h7777_7777_0000_0007);
		stim[17] = makeRow(mulDivPkg::opDivS, 1'b1, 64'hAAAA_AAAA_8000_0000, 64'h5555_5555_FFFF_FFFF);
		stim[18] = makeRow(mulDivPkg::opDivU, 1'b1, 64'h1111_1111_8765_4321, 64'hFFFF_FFFF_0000_0000);
		stim[19] = makeRow(mulDivPkg::opDivS, 1'b1, 64'h2222_2222_8000_0001, 64'h1234_5678_0000_0000);
		// random rows of any op and mode
		for (int i = FixedRows; i < Rows; i++)
		begin
			seed = xorshift(seed);
			stim[i].op = mulDivPkg::mulDivOp_t'(seed[1:0]);
			stim[i].word = seed[2];
			seed = xorshift(seed);
			stim[i].a[63:32] = seed;
			seed = xorshift(seed);
			stim[i].a[31:0] = seed;
			seed = xorshift(seed);
			stim[i].b[63:32] = seed;
			seed = xorshift(seed);
			stim[i].b[31:0] = seed;
		end
	endtask

	// match a result to its outstanding tag
	task automatic takeResult();
		if (!pending[res.tag])
		begin
			$display("result came back for tag %h with no request outstanding", res.tag);
			stopRun();
		end
		else
		begin
			checkRes(res, expected[res.tag]);
			pending[res.tag] = 1'b0;
			outstanding--;
		end
	endtask

	// advance one cycle to the falling edge and take any result
	task automatic stepCycle();
		@(negedge clock);
		if (resValid)
			takeResult();
	endtask

	// consecutive requests where the one past the lane count is rejected
	task automatic sendBurst(input int first, input int count);
		logic [`MULDIV_TAG_W-1:0] tag;
		for (int k = 0; k < count; k++)
		begin
			tag = `MULDIV_TAG_W'(first + k);
			req.op = stim[first + k].op;
			req.word = stim[first + k].word;
			req.tag = tag;
			req.a = stim[first + k].a;
			req.b = stim[first + k].b;
			reqValid = 1'b1;
			expected[tag] = expectRes(req);
			stepCycle();
			checkReject(reqReject, k == Lanes);
			if (k != Lanes)
			begin
				pending[tag] = 1'b1;
				outstanding++;
			end
		end
		reqValid = 1'b0;
	endtask

	task automatic drain();
		while (outstanding > 0)
		begin
			stepCycle();
			checkReject(reqReject, 1'b0);
		end
	endtask

	initial
	begin
		int r;
		int n;
		arstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		outstanding = 0;
		seed = 32'heea0;
		for (int t = 0; t < Tags; t++)
			pending[t] = 1'b0;
		fillTable();
		// strobes stay low while reset is held
		repeat (2)
		begin
			@(negedge clock);
			if (resValid !== 1'b0)
			begin
				$display("[FAIL] resValid got %h expected %h during reset", resValid, 1'b0);
				stopRun();
			end
			checkReject(reqReject, 1'b0);
		end
		arstN = 1'b1;
		// idle right after reset
		repeat (2)
		begin
			stepCycle();
			checkReject(reqReject, 1'b0);
		end
		// rejected row is resent as the first of the next burst
		r = 0;
		while (r < Rows)
		begin
			n = (Rows - r < Lanes + 1) ? Rows - r : Lanes + 1;
			sendBurst(r, n);
			drain();
			repeat (2) stepCycle();
			r = r + ((n == Lanes + 1) ? Lanes : n);
		end
		// nothing more may come out once drained
		repeat (`MULDIV_DIV_CYCLES + 3)
		begin
			stepCycle();
			checkReject(reqReject, 1'b0);
		end
		$display("=== PASS ===");
		$finish;
	end

	// watchdog allows about one slow lane run per row
	initial
	begin
		#((Rows + 2) * (`MULDIV_DIV_CYCLES + 3) * 4);
		$display("watchdog expired before all results came back");
		stopRun();
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
+incdir+tests
common/mulDivPkg.sv
logic/opDispatch.sv
slowMulDiv/slowMulDivLane.sv
logic/resultCollect.sv
logic/mulDivCluster.sv
tests/mulDivClusterTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module mulDivClusterTb -o mulDivClusterSim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/mulDivClusterSim
